//--- hdl/ntm_pkg.sv
//////////////////////////////
// Widths and types shared by the interface-vector stage
// Arithmetic is unsigned and wraps at DATA_WIDTH bits
// Sizes above 255 do not fit index_t
//////////////////////////////
`default_nettype none

package ntm_pkg;

  // Element and counter widths
  localparam int DATA_WIDTH  = 16;
  localparam int INDEX_WIDTH = 8;

  // One operand or result element
  typedef logic [DATA_WIDTH-1:0]  data_t;
  // Size or row/column index
  typedef logic [INDEX_WIDTH-1:0] index_t;

  // Tag on each output result
  typedef enum logic [2:0] {
    KEY,
    SHIFT,
    BETA,
    GATE,
    GAMMA
  } vector_kind_t;

  // Controller phases, in stream order
  typedef enum logic [2:0] {
    IDLE,
    LOAD_H,
    KEY_ROWS,
    SHIFT_ROWS,
    BETA_DOT,
    GATE_DOT,
    GAMMA_DOT,
    FINISH
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/mac_if.sv
//////////////////////////////
// Controller to MAC engine link
// last is only meaningful together with acc_en
// result is held until the next row completes
//////////////////////////////
`default_nettype none

interface mac_if import ntm_pkg::*; ();

  // Sequencing from the controller
  logic  clear;
  logic  acc_en;
  logic  last;
  // Weight element of the current row
  data_t operand_a;

  // Row dot product, strobed for one cycle
  logic  result_valid;
  data_t result;

  modport controller (
    output clear, acc_en, operand_a, last,
    input  result_valid, result
  );

  modport engine (
    input  clear, acc_en, operand_a, last,
    output result_valid, result
  );

endinterface

`default_nettype wire

//--- hdl/hidden_state_buffer.sv
//////////////////////////////
// Hidden-state store, MAX_L entries
// Read is combinational at the write index
// Entries past MAX_L-1 are never addressed
//////////////////////////////
`default_nettype none

module hidden_state_buffer import ntm_pkg::*; #(
  parameter int MAX_L = 16
) (
  input  logic   CLK,
  input  logic   RST,
  input  logic   wr_en,
  input  data_t  wr_data,
  input  index_t index,
  output data_t  rd_data
);

  // Address bits needed for MAX_L entries, at least one
  localparam int ADDR_W = (MAX_L > 1) ? $clog2(MAX_L) : 1;

  // h[0..L-1]
  data_t mem [MAX_L];

  logic [ADDR_W-1:0] addr;

  // Low bits only, range is held by the controller
  assign addr = index[ADDR_W-1:0];

  // Write port, filled once per run during LOAD_H
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[addr] <= wr_data;
    end
  end

  // Column operand for the MAC engine
  assign rd_data = mem[addr];

  // Column counter must stay inside the array
  a_wr_in_range : assert property (
    @(posedge CLK) disable iff (RST)
    wr_en |-> (index < index_t'(MAX_L))
  ) else $error("hidden_state_buffer write at index %0d", index);

endmodule

`default_nettype wire

//--- hdl/mac_unit.sv
//////////////////////////////
// Multiply-accumulate engine, one dot product per row
// Product and sum keep the low DATA_WIDTH bits
// A new row may start the cycle after last
//////////////////////////////
`default_nettype none

module mac_unit import ntm_pkg::*; (
  input  logic  CLK,
  input  logic  RST,
  mac_if.engine mac,
  input  data_t operand_b
);

  // Running sum of the current row
  data_t acc;
  // Wrapped product of weight and h[column]
  data_t product;
  // Sum including the current element
  data_t acc_next;

  assign product  = mac.operand_a * operand_b;
  assign acc_next = acc + product;

  //////////////////////////////
  // Accumulator
  //////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc <= '0;
    end else if (mac.clear) begin
      // Fresh run
      acc <= '0;
    end else if (mac.acc_en) begin
      // Row done, next row starts from zero
      acc <= mac.last ? '0 : acc_next;
    end
  end

  //////////////////////////////
  // Result register
  //////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      mac.result_valid <= 1'b0;
    end else begin
      // One-cycle strobe per finished row
      mac.result_valid <= mac.acc_en & mac.last;
    end
  end

  // Payload, only read with result_valid
  always_ff @(posedge CLK) begin
    if (mac.acc_en && mac.last) begin
      mac.result <= acc_next;
    end
  end

  // Controller flags row end only on an accepted element
  a_last_with_acc : assert property (
    @(posedge CLK) disable iff (RST)
    mac.last |-> mac.acc_en
  ) else $error("mac_unit last without acc_en");

endmodule

`default_nettype wire

//--- hdl/interface_vector_controller.sv
//////////////////////////////
// Phase FSM for the interface-vector stream
// Order is h, Wk, Ws, wbeta, wg, wgamma
// Sizes are captured on start and must be nonzero
// size_l above MAX_L is not supported
//////////////////////////////
`default_nettype none

module interface_vector_controller import ntm_pkg::*; #(
  parameter int MAX_L = 16
) (
  input  logic          CLK,
  input  logic          RST,
  input  logic          start,
  input  index_t        size_l,
  input  index_t        size_w,
  input  index_t        size_n,
  input  logic          in_valid,
  input  data_t         in_data,
  output logic          in_ready,
  output logic          buf_wr_en,
  output data_t         buf_wr_data,
  output index_t        buf_index,
  mac_if.controller     mac,
  output vector_kind_t  out_kind,
  output logic          done
);

  ctrl_state_t state;
  ctrl_state_t next_phase;

  // Sizes held for the whole run
  index_t size_l_q;
  index_t size_w_q;
  index_t size_n_q;

  // Position inside the current phase
  index_t col;
  index_t row;
  index_t row_limit;

  logic accept;
  logic col_last;
  logic row_last;
  logic mac_phase;
  vector_kind_t phase_kind;

  //////////////////////////////
  // Phase decode
  //////////////////////////////
  always_comb begin
    row_limit  = 8'd1;
    phase_kind = GAMMA;
    next_phase = IDLE;
    case (state)
      LOAD_H: begin
        next_phase = KEY_ROWS;
      end
      KEY_ROWS: begin
        row_limit  = size_w_q;
        phase_kind = KEY;
        next_phase = SHIFT_ROWS;
      end
      SHIFT_ROWS: begin
        row_limit  = size_n_q;
        phase_kind = SHIFT;
        next_phase = BETA_DOT;
      end
      BETA_DOT: begin
        phase_kind = BETA;
        next_phase = GATE_DOT;
      end
      GATE_DOT: begin
        phase_kind = GATE;
        next_phase = GAMMA_DOT;
      end
      GAMMA_DOT: begin
        next_phase = FINISH;
      end
      default: begin
        next_phase = IDLE;
      end
    endcase
  end

  // Ready in every streaming phase, falls after the final wgamma element
  assign in_ready  = (state != IDLE) && (state != FINISH);
  assign accept    = in_valid & in_ready;
  assign col_last  = (col == size_l_q - 1'b1);
  assign row_last  = (row == row_limit - 1'b1);
  assign mac_phase = in_ready && (state != LOAD_H);

  // h goes to the buffer
  assign buf_wr_en   = accept && (state == LOAD_H);
  assign buf_wr_data = in_data;
  // Same column selects h for the MAC engine
  assign buf_index   = col;

  // Weights go to the MAC engine
  assign mac.clear     = (state == IDLE) && start;
  assign mac.acc_en    = accept && mac_phase;
  assign mac.operand_a = in_data;
  assign mac.last      = accept && mac_phase && col_last;

  //////////////////////////////
  // State and counters
  //////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= IDLE;
      col      <= '0;
      row      <= '0;
      size_l_q <= '0;
      size_w_q <= '0;
      size_n_q <= '0;
      out_kind <= KEY;
      done     <= 1'b0;
    end else begin
      // Pulse in the cycle after the gamma result
      done <= (state == FINISH);
      // Tag lines up with result_valid one cycle later
      if (mac.last) begin
        out_kind <= phase_kind;
      end
      case (state)
        IDLE: begin
          // start while busy never reaches here
          if (start) begin
            size_l_q <= size_l;
            size_w_q <= size_w;
            size_n_q <= size_n;
            col      <= '0;
            row      <= '0;
            state    <= LOAD_H;
          end
        end
        FINISH: begin
          state <= IDLE;
        end
        default: begin
          // Counters move only on accepted elements
          if (accept) begin
            if (col_last) begin
              col <= '0;
              if (row_last) begin
                row   <= '0;
                state <= next_phase;
              end else begin
                row <= row + 1'b1;
              end
            end else begin
              col <= col + 1'b1;
            end
          end
        end
      endcase
    end
  end

  // Captured sizes within the supported range
  a_sizes_valid : assert property (
    @(posedge CLK) disable iff (RST)
    (state == IDLE && start) |=> (size_l_q != '0 && size_w_q != '0 && size_n_q != '0 &&
                                  size_l_q <= index_t'(MAX_L))
  ) else $error("sizes out of range L=%0d W=%0d N=%0d", size_l_q, size_w_q, size_n_q);

endmodule

`default_nettype wire

//--- hdl/ntm_interface_vector.sv
//////////////////////////////
// NTM interface-vector stage, top level
// One element in per accepted in_valid & in_ready
// out_valid is a strobe, no back-pressure
// size_l must not exceed MAX_L
//////////////////////////////
`default_nettype none

module ntm_interface_vector import ntm_pkg::*; #(
  parameter int MAX_L = 16
) (
  input  logic         CLK,
  input  logic         RST,
  input  logic         start,
  input  index_t       size_l,
  input  index_t       size_w,
  input  index_t       size_n,
  input  logic         in_valid,
  input  data_t        in_data,
  output logic         in_ready,
  output logic         out_valid,
  output data_t        out_data,
  output vector_kind_t out_kind,
  output logic         done
);

  // Buffer side
  logic   buf_wr_en;
  data_t  buf_wr_data;
  index_t buf_index;
  // h[column] into the MAC engine
  data_t  h_elem;

  mac_if mac_bus ();

  hidden_state_buffer #(
    .MAX_L (MAX_L)
  ) u_buffer (
    .CLK     (CLK),
    .RST     (RST),
    .wr_en   (buf_wr_en),
    .wr_data (buf_wr_data),
    .index   (buf_index),
    .rd_data (h_elem)
  );

  interface_vector_controller #(
    .MAX_L (MAX_L)
  ) u_controller (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .size_l      (size_l),
    .size_w      (size_w),
    .size_n      (size_n),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .in_ready    (in_ready),
    .buf_wr_en   (buf_wr_en),
    .buf_wr_data (buf_wr_data),
    .buf_index   (buf_index),
    .mac         (mac_bus.controller),
    .out_kind    (out_kind),
    .done        (done)
  );

  mac_unit u_mac (
    .CLK       (CLK),
    .RST       (RST),
    .mac       (mac_bus.engine),
    .operand_b (h_elem)
  );

  // Results leave straight from the engine register
  assign out_valid = mac_bus.result_valid;
  assign out_data  = mac_bus.result;

endmodule

`default_nettype wire

//--- verification/tb_ntm_interface_vector.sv
//////////////////////////////
// Testbench for the NTM interface-vector stage
// Drives the element stream 1 ns after each rising CLK
// Results are checked at the falling edge against a local model
// Run length is bounded by a cycle counter
//////////////////////////////
`default_nettype none

module tb_ntm_interface_vector import ntm_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_L = 16;

  // Stream length of one run is h plus W + N + 3 rows of L
  function automatic int stream_length(input int l, input int w, input int n);
    return l + (w + n + 3) * l;
  endfunction

  // Elements over all runs bound the simulation
  localparam int TOTAL_ELEMS = stream_length(1, 1, 1) + 2 * stream_length(8, 6, 5) +
                               stream_length(16, 4, 3) + stream_length(5, 3, 2) +
                               stream_length(12, 7, 4);
  localparam int CYCLE_LIMIT = 2 * TOTAL_ELEMS + 1000;

  logic         CLK;
  logic         RST;
  logic         start;
  index_t       size_l;
  index_t       size_w;
  index_t       size_n;
  logic         in_valid;
  data_t        in_data;
  logic         in_ready;
  logic         out_valid;
  data_t        out_data;
  vector_kind_t out_kind;
  logic         done;

  integer seed = 32'h197e;
  int     cycle_count = 0;
  int     error_count = 0;
  int     done_count = 0;
  int     checked_count = 0;
  int     tests_run = 0;
  int     tests_ok = 0;

  // Operands of the current run in stream order
  data_t        stream[$];
  // Expected results with the oldest first
  data_t        exp_data[$];
  vector_kind_t exp_kind[$];
  data_t        exp_d;
  vector_kind_t exp_k;

  ntm_interface_vector #(
    .MAX_L (MAX_L)
  ) DUT (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .size_l    (size_l),
    .size_w    (size_w),
    .size_n    (size_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_kind  (out_kind),
    .done      (done)
  );

  // 100 ns clock
  always #50 CLK = ~CLK;

  //////////////////////////////
  // Reference model
  //////////////////////////////
  // Row at base dotted with h and wrapped to 16 bits
  function automatic data_t dot_ref(input int base, input int len);
    data_t       acc;
    logic [31:0] prod;
    acc = '0;
    for (int i = 0; i < len; i++) begin
      prod = 32'(stream[base + i]) * 32'(stream[i]);
      acc  = acc + prod[15:0];
    end
    return acc;
  endfunction

  // Queue k, s, beta, g, gamma in output order
  task automatic load_expected(input int l, input int w, input int n);
    int base;
    base = l;
    for (int r = 0; r < w; r++) begin
      exp_data.push_back(dot_ref(base, l));
      exp_kind.push_back(KEY);
      base += l;
    end
    for (int r = 0; r < n; r++) begin
      exp_data.push_back(dot_ref(base, l));
      exp_kind.push_back(SHIFT);
      base += l;
    end
    exp_data.push_back(dot_ref(base, l));
    exp_kind.push_back(BETA);
    base += l;
    exp_data.push_back(dot_ref(base, l));
    exp_kind.push_back(GATE);
    base += l;
    exp_data.push_back(dot_ref(base, l));
    exp_kind.push_back(GAMMA);
  endtask

  // Random operands or all ones for the wrap test
  task automatic build_stream(input int l, input int w, input int n, input bit all_ones);
    int r;
    stream.delete();
    for (int i = 0; i < stream_length(l, w, n); i++) begin
      r = $random(seed);
      stream.push_back(all_ones ? 16'hFFFF : r[15:0]);
    end
  endtask

  //////////////////////////////
  // One run through the DUT
  //////////////////////////////
  task automatic run_stream(input string name, input int l, input int w, input int n,
                            input int gap_pct, input bit all_ones, input int restart_at);
    int   total;
    int   idx;
    int   r;
    int   done_before;
    int   errors_before;
    int   wait_cycles;
    bit   valid;
    logic ready_now;
    errors_before = error_count;
    build_stream(l, w, n, all_ones);
    load_expected(l, w, n);
    total       = stream.size();
    done_before = done_count;

    // Start pulse with the sizes
    size_l = index_t'(l);
    size_w = index_t'(w);
    size_n = index_t'(n);
    start  = 1'b1;
    @(posedge CLK);
    #1;
    start = 1'b0;

    idx = 0;
    while (idx < total) begin
      ready_now = in_ready;
      if (ready_now !== 1'b1) begin
        $display("in_ready low with %0d of %0d elements still to send", total - idx, total);
        error_count++;
      end
      r     = $random(seed);
      valid = 1'b1;
      if (gap_pct > 0) begin
        valid = ((r & 32'h7fffffff) % 100) >= gap_pct;
      end
      // Stray start and other sizes in the middle of Wk are ignored
      start = (idx == restart_at);
      if (idx == restart_at) begin
        size_l = index_t'(l + 1);
        size_w = 8'd9;
        size_n = 8'd9;
      end
      in_valid = valid;
      in_data  = valid ? stream[idx] : r[31:16];
      @(posedge CLK);
      #1;
      if (valid && ready_now === 1'b1) begin
        idx++;
      end
    end
    in_valid = 1'b0;
    start    = 1'b0;
    if (in_ready !== 1'b0) begin
      $display("in_ready still high after the final element was accepted");
      error_count++;
    end

    // Wait for done and make sure it was a single pulse
    wait_cycles = 0;
    while (done_count == done_before && wait_cycles < 20) begin
      @(posedge CLK);
      wait_cycles++;
    end
    if (done_count == done_before) begin
      $display("done did not arrive within 20 cycles after the final element");
      error_count++;
    end
    repeat (3) @(posedge CLK);
    #1;
    if (done_count > done_before + 1) begin
      $display("done pulsed %0d times in one run", done_count - done_before);
      error_count++;
    end
    if (exp_data.size() != 0) begin
      $display("%0d expected results never appeared on out_valid", exp_data.size());
      error_count++;
      exp_data.delete();
      exp_kind.delete();
    end

    tests_run++;
    if (error_count == errors_before) begin
      tests_ok++;
      $display("Test %s L=%0d W=%0d N=%0d: ok", name, l, w, n);
    end else begin
      $display("Test %s L=%0d W=%0d N=%0d: %0d errors", name, l, w, n,
               error_count - errors_before);
    end
  endtask

  //////////////////////////////
  // Result checker
  //////////////////////////////
  always @(negedge CLK) begin
    if (!RST) begin
      if (done) begin
        done_count++;
      end
      if (out_valid) begin
        if (exp_data.size() == 0) begin
          $display("Extra out_valid with no result pending, out_data %h", out_data);
          error_count++;
        end else begin
          exp_d = exp_data.pop_front();
          exp_k = exp_kind.pop_front();
          checked_count++;
          if (out_data !== exp_d) begin
            $display("Error: out_data %h, expected %h", out_data, exp_d);
            error_count++;
          end
          if (out_kind !== exp_k) begin
            $display("Error: out_kind %h, expected %h", out_kind, exp_k);
            error_count++;
          end
        end
      end
    end
  end

  // Watchdog
  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles without finishing", cycle_count);
      $display("*** FAILED ***");
      $finish;
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    CLK      = 1'b0;
    RST      = 1'b1;
    start    = 1'b0;
    size_l   = '0;
    size_w   = '0;
    size_n   = '0;
    in_valid = 1'b0;
    in_data  = '0;

    repeat (8) @(posedge CLK);
    #1;
    if (in_ready !== 1'b0 || out_valid !== 1'b0 || done !== 1'b0) begin
      $display("Error: in_ready %h out_valid %h done %h during reset, expected 0",
               in_ready, out_valid, done);
      error_count++;
    end
    RST = 1'b0;
    @(posedge CLK);
    #1;

    run_stream("1 minimal", 1, 1, 1, 0, 1'b0, -1);
    run_stream("2 random", 8, 6, 5, 0, 1'b0, -1);
    // Roughly one cycle in three idle
    run_stream("3 gaps", 8, 6, 5, 35, 1'b0, -1);
    run_stream("4 wrap", MAX_L, 4, 3, 0, 1'b1, -1);
    run_stream("5a restart", 5, 3, 2, 20, 1'b0, 8);
    run_stream("5b restart", 12, 7, 4, 0, 1'b0, 40);

    $display("Tests run %0d, ok %0d, results checked %0d, errors %0d",
             tests_run, tests_ok, checked_count, error_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
hdl/ntm_pkg.sv
hdl/mac_if.sv
hdl/hidden_state_buffer.sv
hdl/mac_unit.sv
hdl/interface_vector_controller.sv
hdl/ntm_interface_vector.sv
verification/tb_ntm_interface_vector.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ntm_interface_vector -f build.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_ntm_interface_vector)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qxF '*** PASSED ***'; then
  exit 0
fi
exit 1
